/* Bender.yml */
package:
  name: analog_wrap

sources:
  - files:
      - rtl/analog_wrap_pkg.sv
      - rtl/analog_wrap_ctrl.sv
      - rtl/weight_write_path.sv
      - rtl/spin_write_path.sv
      - rtl/spin_capture.sv
      - rtl/analog_wrap.sv
  - target: test
    files:
      - test/analog_wrap_asserts.sv
      - test/tb_analog_wrap.sv

/* analog_wrap.f */
rtl/analog_wrap_pkg.sv
rtl/analog_wrap_ctrl.sv
rtl/weight_write_path.sv
rtl/spin_write_path.sv
rtl/spin_capture.sv
rtl/analog_wrap.sv
test/analog_wrap_asserts.sv
test/tb_analog_wrap.sv

/* rtl/analog_wrap.sv */
// top of the analog macro wrapper, connects the sequencer to the weight, spin write and capture paths
`timescale 1ns/1ps

module analog_wrap #(
    parameter int NUM_SPIN        = analog_wrap_pkg::NUM_SPIN_DEF,
    parameter int BITDATA         = analog_wrap_pkg::BITDATA_DEF,
    parameter int SPIN_WBL_OFFSET = 0,
    localparam int ADDR_W         = (NUM_SPIN > 1) ? $clog2(NUM_SPIN) : 1,
    localparam int WBL_W          = NUM_SPIN * BITDATA
) (
    input  logic                         clk_i,
    input  logic                         reset_i,
    // configuration
    input  logic                         cfg_load_i,
    input  analog_wrap_pkg::timing_cfg_t cfg_i,
    input  logic [NUM_SPIN-1:0]          spin_wwl_strobe_i,
    input  logic [NUM_SPIN-1:0]          spin_feedback_i,
    // weight memory side
    input  logic                         dt_cfg_enable_i,
    output logic                         j_mem_ren_o,
    output logic [ADDR_W-1:0]            j_raddr_o,
    input  logic [WBL_W-1:0]             j_rdata_i,
    output logic                         h_ren_o,
    input  logic [WBL_W-1:0]             h_rdata_i,
    // macro word and bit lines
    output logic [NUM_SPIN-1:0]          j_one_hot_wwl_o,
    output logic                         h_wwl_o,
    output logic [WBL_W-1:0]             wbl_o,
    output logic [WBL_W-1:0]             wblb_o,
    // spin in
    input  logic                         spin_pop_valid_i,
    output logic                         spin_pop_ready_o,
    input  logic [NUM_SPIN-1:0]          spin_pop_i,
    output logic [NUM_SPIN-1:0]          spin_wwl_o,
    output logic [NUM_SPIN-1:0]          spin_feedback_o,
    // spin out
    input  logic [NUM_SPIN-1:0]          spin_analog_i,
    output logic                         spin_valid_o,
    input  logic                         spin_ready_i,
    output logic [NUM_SPIN-1:0]          spin_o,
    // status
    output logic                         dt_cfg_idle_o,
    output logic                         analog_rx_idle_o,
    output logic                         analog_tx_idle_o
);
    import analog_wrap_pkg::*;

    ctrl_state_t      state;
    sync_sel_t        sync_depth;
    logic             row_step;
    logic             row_last;
    logic             pop_take;
    logic             capture_start;
    logic             capture_done;
    logic             bypass_conv;
    logic             wt_phase;
    logic [WBL_W-1:0] wt_wbl;
    logic [WBL_W-1:0] sp_wbl;

    analog_wrap_ctrl u_ctrl (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .cfg_load_i       (cfg_load_i),
        .cfg_i            (cfg_i),
        .dt_cfg_enable_i  (dt_cfg_enable_i),
        .spin_pop_valid_i (spin_pop_valid_i),
        .spin_ready_i     (spin_ready_i),
        .capture_done_i   (capture_done),
        .state_o          (state),
        .row_last_i       (row_last),
        .row_step_o       (row_step),
        .pop_take_o       (pop_take),
        .capture_start_o  (capture_start),
        .out_take_o       (),
        .bypass_conv_o    (bypass_conv),
        .sync_depth_o     (sync_depth),
        .spin_pop_ready_o (spin_pop_ready_o),
        .spin_valid_o     (spin_valid_o),
        .dt_cfg_idle_o    (dt_cfg_idle_o),
        .analog_rx_idle_o (analog_rx_idle_o),
        .analog_tx_idle_o (analog_tx_idle_o)
    );

    weight_write_path #(
        .NUM_SPIN (NUM_SPIN),
        .BITDATA  (BITDATA)
    ) u_weight_write (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .state_i         (state),
        .row_step_i      (row_step),
        .bypass_conv_i   (bypass_conv),
        .row_last_o      (row_last),
        .j_mem_ren_o     (j_mem_ren_o),
        .j_raddr_o       (j_raddr_o),
        .j_rdata_i       (j_rdata_i),
        .h_ren_o         (h_ren_o),
        .h_rdata_i       (h_rdata_i),
        .j_one_hot_wwl_o (j_one_hot_wwl_o),
        .h_wwl_o         (h_wwl_o),
        .wt_wbl_o        (wt_wbl)
    );

    spin_write_path #(
        .NUM_SPIN        (NUM_SPIN),
        .BITDATA         (BITDATA),
        .SPIN_WBL_OFFSET (SPIN_WBL_OFFSET)
    ) u_spin_write (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .cfg_load_i        (cfg_load_i),
        .spin_wwl_strobe_i (spin_wwl_strobe_i),
        .spin_feedback_i   (spin_feedback_i),
        .pop_take_i        (pop_take),
        .spin_pop_i        (spin_pop_i),
        .state_i           (state),
        .spin_wwl_o        (spin_wwl_o),
        .spin_feedback_o   (spin_feedback_o),
        .sp_wbl_o          (sp_wbl)
    );

    spin_capture #(
        .NUM_SPIN (NUM_SPIN)
    ) u_spin_capture (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .capture_start_i (capture_start),
        .sync_depth_i    (sync_depth),
        .spin_analog_i   (spin_analog_i),
        .capture_done_o  (capture_done),
        .spin_o          (spin_o)
    );

    // weight phases drive differential bit lines, spin phases single ended
    assign wt_phase = state inside {WT_READ, WT_HIGH, WT_LOW};
    assign wbl_o    = wt_phase ? wt_wbl : sp_wbl;
    assign wblb_o   = wt_phase ? ~wt_wbl : '0;

endmodule

/* rtl/analog_wrap_ctrl.sv */
// phase sequencer of the wrapper, holds the timing config and the phase counter, owns both spin handshakes
`timescale 1ns/1ps

module analog_wrap_ctrl (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         cfg_load_i,
    input  analog_wrap_pkg::timing_cfg_t cfg_i,
    input  logic                         dt_cfg_enable_i,
    input  logic                         spin_pop_valid_i,
    input  logic                         spin_ready_i,
    input  logic                         capture_done_i,
    output analog_wrap_pkg::ctrl_state_t state_o,
    input  logic                         row_last_i,
    output logic                         row_step_o,
    output logic                         pop_take_o,
    output logic                         capture_start_o,
    output logic                         out_take_o,
    output logic                         bypass_conv_o,
    output analog_wrap_pkg::sync_sel_t   sync_depth_o,
    output logic                         spin_pop_ready_o,
    output logic                         spin_valid_o,
    output logic                         dt_cfg_idle_o,
    output logic                         analog_rx_idle_o,
    output logic                         analog_tx_idle_o
);
    import analog_wrap_pkg::*;

    localparam timing_cfg_t CFG_RESET = '{
        wwl_high:     '0,
        wwl_low:      '0,
        spin_write:   '0,
        spin_compute: '0,
        sync_depth:   sync_sel_t'(1),
        bypass_conv:  1'b0
    };

    timing_cfg_t cfg_q;
    ctrl_state_t state_q;
    ctrl_state_t state_d;
    cnt_t        cnt_q;
    cnt_t        cnt_d;
    logic        cnt_zero;

    // counter runs len-1 down to 0, a zero length still takes one cycle
    function automatic cnt_t first_count(cnt_t len);
        return (len == '0) ? '0 : len - 1'b1;
    endfunction

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cfg_q <= CFG_RESET;
        end else if (cfg_load_i) begin
            cfg_q <= cfg_i;
        end
    end

    assign cnt_zero = (cnt_q == '0);

    // a weight start wins over a pending pop in the same cycle
    assign spin_pop_ready_o = (state_q == IDLE) && !dt_cfg_enable_i;
    assign pop_take_o       = spin_pop_valid_i && spin_pop_ready_o;
    assign spin_valid_o     = (state_q == SP_OUT);
    assign out_take_o       = spin_valid_o && spin_ready_i;
    assign row_step_o       = (state_q == WT_LOW) && cnt_zero;
    assign capture_start_o  = (state_q == SP_COMPUTE) && cnt_zero;

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_zero ? cnt_q : cnt_q - 1'b1;
        case (state_q)
            IDLE: begin
                if (dt_cfg_enable_i) begin
                    state_d = WT_READ;
                end else if (pop_take_o) begin
                    state_d = SP_WRITE;
                    cnt_d   = first_count(cfg_q.spin_write);
                end
            end
            WT_READ: begin
                state_d = WT_HIGH;
                cnt_d   = first_count(cfg_q.wwl_high);
            end
            WT_HIGH: begin
                if (cnt_zero) begin
                    state_d = WT_LOW;
                    cnt_d   = first_count(cfg_q.wwl_low);
                end
            end
            WT_LOW: begin
                // H row is the last one of the sequence
                if (row_step_o) begin
                    state_d = row_last_i ? IDLE : WT_READ;
                end
            end
            SP_WRITE: begin
                if (cnt_zero) begin
                    state_d = SP_COMPUTE;
                    cnt_d   = first_count(cfg_q.spin_compute);
                end
            end
            SP_COMPUTE: begin
                if (capture_start_o) begin
                    state_d = SP_CAPTURE;
                end
            end
            SP_CAPTURE: begin
                if (capture_done_i) begin
                    state_d = SP_OUT;
                end
            end
            SP_OUT: begin
                if (out_take_o) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    assign state_o       = state_q;
    assign bypass_conv_o = cfg_q.bypass_conv;
    assign sync_depth_o  = cfg_q.sync_depth;

    assign dt_cfg_idle_o    = !(state_q inside {WT_READ, WT_HIGH, WT_LOW});
    assign analog_rx_idle_o = !(state_q inside {SP_WRITE, SP_COMPUTE});
    assign analog_tx_idle_o = !(state_q inside {SP_CAPTURE, SP_OUT});

endmodule

/* rtl/analog_wrap_pkg.sv */
// shared defaults, timing config layout and controller states for the analog macro wrapper
package analog_wrap_pkg;

    // width of every cycle count in the timing config
    localparam int CNT_W = 16;

    // deepest synchronizer tap on the spin capture path
    localparam int SYNC_MAX = 3;

    localparam int NUM_SPIN_DEF = 16;
    localparam int BITDATA_DEF  = 4;

    typedef logic [CNT_W-1:0] cnt_t;

    // synchronizer depth, 1 to SYNC_MAX
    typedef logic [1:0] sync_sel_t;

    typedef struct packed {
        cnt_t      wwl_high;
        cnt_t      wwl_low;
        cnt_t      spin_write;
        cnt_t      spin_compute;
        sync_sel_t sync_depth;
        logic      bypass_conv;
    } timing_cfg_t;

    typedef enum logic [2:0] {
        IDLE,
        WT_READ,
        WT_HIGH,
        WT_LOW,
        SP_WRITE,
        SP_COMPUTE,
        SP_CAPTURE,
        SP_OUT
    } ctrl_state_t;

endpackage

/* rtl/spin_capture.sv */
// spin capture, synchronizes the macro spin outputs at a selectable depth and holds the result
`timescale 1ns/1ps

module spin_capture #(
    parameter int NUM_SPIN = analog_wrap_pkg::NUM_SPIN_DEF
) (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       capture_start_i,
    input  analog_wrap_pkg::sync_sel_t sync_depth_i,
    input  logic [NUM_SPIN-1:0]        spin_analog_i,
    output logic                       capture_done_o,
    output logic [NUM_SPIN-1:0]        spin_o
);
    import analog_wrap_pkg::*;

    logic [NUM_SPIN-1:0] sync_q [SYNC_MAX];
    logic [NUM_SPIN-1:0] tap;
    sync_sel_t           depth_eff;
    sync_sel_t           left_q;
    logic                busy_q;

    // depth 0 behaves as depth 1
    assign depth_eff = (sync_depth_i == '0) ? sync_sel_t'(1) : sync_depth_i;

    // free-running chain, the macro outputs are asynchronous to clk_i
    always_ff @(posedge clk_i) begin
        sync_q[0] <= spin_analog_i;
        for (int k = 1; k < SYNC_MAX; k++) begin
            sync_q[k] <= sync_q[k-1];
        end
    end

    assign tap = sync_q[depth_eff - 1'b1];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            left_q <= '0;
        end else if (capture_start_i) begin
            busy_q <= 1'b1;
            left_q <= depth_eff;
        end else if (capture_done_o) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            left_q <= left_q - 1'b1;
        end
    end

    // high in the last capture cycle
    assign capture_done_o = busy_q && (left_q == sync_sel_t'(1));

    always_ff @(posedge clk_i) begin
        if (capture_done_o) begin
            spin_o <= tap;
        end
    end

endmodule

/* rtl/spin_write_path.sv */
// spin write datapath, holds the masks and the popped spin word and drives the spin word lines
`timescale 1ns/1ps

module spin_write_path #(
    parameter int NUM_SPIN        = analog_wrap_pkg::NUM_SPIN_DEF,
    parameter int BITDATA         = analog_wrap_pkg::BITDATA_DEF,
    parameter int SPIN_WBL_OFFSET = 0
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          cfg_load_i,
    input  logic [NUM_SPIN-1:0]           spin_wwl_strobe_i,
    input  logic [NUM_SPIN-1:0]           spin_feedback_i,
    input  logic                          pop_take_i,
    input  logic [NUM_SPIN-1:0]           spin_pop_i,
    input  analog_wrap_pkg::ctrl_state_t  state_i,
    output logic [NUM_SPIN-1:0]           spin_wwl_o,
    output logic [NUM_SPIN-1:0]           spin_feedback_o,
    output logic [NUM_SPIN*BITDATA-1:0]   sp_wbl_o
);
    import analog_wrap_pkg::*;

    // bit-line pattern of a spin that is set
    localparam logic [BITDATA-1:0] SPIN_BIT = 1 << SPIN_WBL_OFFSET;

    logic [NUM_SPIN-1:0] strobe_q;
    logic [NUM_SPIN-1:0] feedback_q;
    logic [NUM_SPIN-1:0] spin_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            strobe_q   <= '0;
            feedback_q <= '0;
        end else if (cfg_load_i) begin
            strobe_q   <= spin_wwl_strobe_i;
            feedback_q <= spin_feedback_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_take_i) begin
            spin_q <= spin_pop_i;
        end
    end

    assign spin_wwl_o      = (state_i == SP_WRITE) ? strobe_q : '0;
    assign spin_feedback_o = (state_i inside {SP_WRITE, SP_COMPUTE}) ? feedback_q : '0;

    for (genvar i = 0; i < NUM_SPIN; i++) begin : g_expand
        assign sp_wbl_o[i*BITDATA +: BITDATA] = spin_q[i] ? SPIN_BIT : '0;
    end

endmodule

/* rtl/weight_write_path.sv */
// weight write datapath, steps through J rows and the H row and drives word lines and bit lines
`timescale 1ns/1ps

module weight_write_path #(
    parameter int NUM_SPIN   = analog_wrap_pkg::NUM_SPIN_DEF,
    parameter int BITDATA    = analog_wrap_pkg::BITDATA_DEF,
    localparam int ADDR_W    = (NUM_SPIN > 1) ? $clog2(NUM_SPIN) : 1,
    localparam int WBL_W     = NUM_SPIN * BITDATA
) (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  analog_wrap_pkg::ctrl_state_t state_i,
    input  logic                         row_step_i,
    input  logic                         bypass_conv_i,
    output logic                         row_last_o,
    output logic                         j_mem_ren_o,
    output logic [ADDR_W-1:0]            j_raddr_o,
    input  logic [WBL_W-1:0]             j_rdata_i,
    output logic                         h_ren_o,
    input  logic [WBL_W-1:0]             h_rdata_i,
    output logic [NUM_SPIN-1:0]          j_one_hot_wwl_o,
    output logic                         h_wwl_o,
    output logic [WBL_W-1:0]             wt_wbl_o
);
    import analog_wrap_pkg::*;

    // rows 0..NUM_SPIN-1 are J, row NUM_SPIN is H
    localparam int ROW_W = $clog2(NUM_SPIN + 1);
    localparam logic [NUM_SPIN-1:0] WWL_ONE = 1;

    typedef logic [ROW_W-1:0] row_t;

    row_t             row_q;
    logic             rd_pending_q;
    logic [WBL_W-1:0] row_data_q;
    logic [WBL_W-1:0] row_data;

    always_ff @(posedge clk_i) begin
        if (reset_i || state_i == IDLE) begin
            row_q <= '0;
        end else if (row_step_i) begin
            row_q <= row_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_pending_q <= 1'b0;
        end else begin
            rd_pending_q <= (state_i == WT_READ);
        end
    end

    assign row_last_o  = (row_q == row_t'(NUM_SPIN));
    assign j_mem_ren_o = (state_i == WT_READ) && !row_last_o;
    assign h_ren_o     = (state_i == WT_READ) && row_last_o;
    assign j_raddr_o   = row_q[ADDR_W-1:0];

    // memory data shows up in the first high cycle and is held from then on
    assign row_data = rd_pending_q ? (row_last_o ? h_rdata_i : j_rdata_i) : row_data_q;

    always_ff @(posedge clk_i) begin
        if (rd_pending_q) begin
            row_data_q <= row_data;
        end
    end

    // two's complement to sign-magnitude per field
    for (genvar i = 0; i < NUM_SPIN; i++) begin : g_conv
        logic [BITDATA-1:0] field;
        logic [BITDATA-1:0] neg;
        logic [BITDATA-1:0] sm;

        assign field = row_data[i*BITDATA +: BITDATA];
        assign neg   = ~field + 1'b1;
        // most negative value saturates to the largest magnitude
        assign sm    = !field[BITDATA-1] ? field :
                       {1'b1, neg[BITDATA-1] ? {(BITDATA-1){1'b1}} : neg[BITDATA-2:0]};
        assign wt_wbl_o[i*BITDATA +: BITDATA] = bypass_conv_i ? field : sm;
    end

    assign j_one_hot_wwl_o = (state_i == WT_HIGH && !row_last_o) ? (WWL_ONE << row_q) : '0;
    assign h_wwl_o         = (state_i == WT_HIGH) && row_last_o;

endmodule

/* test/analog_wrap_asserts.sv */
// concurrent checks bound onto the wrapper top level, spin output hold and word/bit line rules
`timescale 1ns/1ps

module tb_analog_wrap_asserts #(
    parameter int NUM_SPIN = analog_wrap_pkg::NUM_SPIN_DEF,
    parameter int BITDATA  = analog_wrap_pkg::BITDATA_DEF
) (
    input logic                        clk_i,
    input logic                        reset_i,
    input logic                        spin_valid_o,
    input logic                        spin_ready_i,
    input logic [NUM_SPIN-1:0]         spin_o,
    input logic [NUM_SPIN-1:0]         j_one_hot_wwl_o,
    input logic [NUM_SPIN-1:0]         spin_wwl_o,
    input logic [NUM_SPIN*BITDATA-1:0] wblb_o
);
    int hold_errs   = 0;
    int onehot_errs = 0;
    int wblb_errs   = 0;
    int fail_count;

    assign fail_count = hold_errs + onehot_errs + wblb_errs;

    // output word must not move while the consumer stalls
    spin_out_held: assert property (@(posedge clk_i) disable iff (reset_i)
        spin_valid_o && !spin_ready_i |=> spin_valid_o && $stable(spin_o))
    else begin
        $error("spin output dropped or changed before it was accepted");
        hold_errs++;
    end

    j_wwl_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(j_one_hot_wwl_o))
    else begin
        $error("more than one J word line active");
        onehot_errs++;
    end

    spin_wblb_zero: assert property (@(posedge clk_i) disable iff (reset_i)
        (spin_wwl_o != '0) |-> (wblb_o == '0))
    else begin
        $error("inverted bit lines active during spin write");
        wblb_errs++;
    end

endmodule

/* test/tb_analog_wrap.sv */
// testbench for the analog macro wrapper, directed weight write, spin write and capture tests
`timescale 1ns/1ps

module tb_analog_wrap;
    import analog_wrap_pkg::*;

    localparam int NUM_SPIN        = 8;
    localparam int BITDATA         = 4;
    localparam int SPIN_WBL_OFFSET = 1;
    localparam int WBL_W           = NUM_SPIN * BITDATA;
    localparam int ADDR_W          = $clog2(NUM_SPIN);
    localparam int TIMEOUT_CYCLES  = 1000;

    localparam int WWL_HIGH     = 3;
    localparam int WWL_LOW      = 2;
    localparam int SPIN_WRITE   = 4;
    localparam int SPIN_COMPUTE = 5;

    localparam logic [NUM_SPIN-1:0] STROBE_MASK   = 8'hB5;
    localparam logic [NUM_SPIN-1:0] FEEDBACK_MASK = 8'h3C;

    logic                clk_i;
    logic                reset_i;
    logic                cfg_load_i;
    timing_cfg_t         cfg_i;
    logic [NUM_SPIN-1:0] spin_wwl_strobe_i;
    logic [NUM_SPIN-1:0] spin_feedback_i;
    logic                dt_cfg_enable_i;
    logic                j_mem_ren_o;
    logic [ADDR_W-1:0]   j_raddr_o;
    logic [WBL_W-1:0]    j_rdata_i;
    logic                h_ren_o;
    logic [WBL_W-1:0]    h_rdata_i;
    logic [NUM_SPIN-1:0] j_one_hot_wwl_o;
    logic                h_wwl_o;
    logic [WBL_W-1:0]    wbl_o;
    logic [WBL_W-1:0]    wblb_o;
    logic                spin_pop_valid_i;
    logic                spin_pop_ready_o;
    logic [NUM_SPIN-1:0] spin_pop_i;
    logic [NUM_SPIN-1:0] spin_wwl_o;
    logic [NUM_SPIN-1:0] spin_feedback_o;
    logic [NUM_SPIN-1:0] spin_analog_i;
    logic                spin_valid_o;
    logic                spin_ready_i;
    logic [NUM_SPIN-1:0] spin_o;
    logic                dt_cfg_idle_o;
    logic                analog_rx_idle_o;
    logic                analog_tx_idle_o;

    // index NUM_SPIN holds the H row
    logic [WBL_W-1:0]    weight_mem [NUM_SPIN+1];
    logic [15:0]         lfsr_q;
    logic                read_j;
    logic                read_h;
    logic [ADDR_W-1:0]   read_addr;

    analog_wrap #(
        .NUM_SPIN        (NUM_SPIN),
        .BITDATA         (BITDATA),
        .SPIN_WBL_OFFSET (SPIN_WBL_OFFSET)
    ) u_analog_wrap (.*);

    bind analog_wrap tb_analog_wrap_asserts #(
        .NUM_SPIN (NUM_SPIN),
        .BITDATA  (BITDATA)
    ) u_asserts (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .spin_valid_o    (spin_valid_o),
        .spin_ready_i    (spin_ready_i),
        .spin_o          (spin_o),
        .j_one_hot_wwl_o (j_one_hot_wwl_o),
        .spin_wwl_o      (spin_wwl_o),
        .wblb_o          (wblb_o)
    );

    always #5 clk_i = ~clk_i;

    // J/H memory with one cycle read latency
    always @(posedge clk_i) begin
        read_j    = j_mem_ren_o;
        read_h    = h_ren_o;
        read_addr = j_raddr_o;
        #1;
        if (read_j) begin
            j_rdata_i = weight_mem[read_addr];
        end
        if (read_h) begin
            h_rdata_i = weight_mem[NUM_SPIN];
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic fill_weights();
        for (int r = 0; r <= NUM_SPIN; r++) begin
            for (int b = 0; b < WBL_W; b++) begin
                weight_mem[r][b] = lfsr_q[0];
                lfsr_q = lfsr_step(lfsr_q);
            end
        end
        // most negative field must show up at least once
        weight_mem[1][7:4] = 4'h8;
    endtask

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_with_failure("check failed");
        end
    endtask

    task automatic guard_wait(input int waited, input string what);
        if (waited >= TIMEOUT_CYCLES) begin
            stop_with_failure({"timed out waiting for ", what});
        end
    endtask

    always @(posedge clk_i) begin
        if (u_analog_wrap.u_asserts.fail_count != 0) begin
            stop_with_failure("a bound assertion failed");
        end
    end

    // two's complement fields to sign-magnitude, saturating at the largest magnitude
    function automatic logic [WBL_W-1:0] sign_mag_row(input logic [WBL_W-1:0] row,
                                                      input logic bypass);
        logic [WBL_W-1:0]   res;
        logic [BITDATA-1:0] field;
        int                 val;
        int                 mag;
        res = row;
        if (!bypass) begin
            for (int i = 0; i < NUM_SPIN; i++) begin
                field = row[i*BITDATA +: BITDATA];
                val   = field;
                if (field[BITDATA-1]) begin
                    val = val - (1 << BITDATA);
                    mag = -val;
                    if (mag > (1 << (BITDATA-1)) - 1) begin
                        mag = (1 << (BITDATA-1)) - 1;
                    end
                    res[i*BITDATA +: BITDATA] = (1 << (BITDATA-1)) | mag;
                end
            end
        end
        return res;
    endfunction

    function automatic logic [WBL_W-1:0] spin_field_row(input logic [NUM_SPIN-1:0] spin);
        logic [WBL_W-1:0] res;
        res = '0;
        for (int i = 0; i < NUM_SPIN; i++) begin
            if (spin[i]) begin
                res[i*BITDATA + SPIN_WBL_OFFSET] = 1'b1;
            end
        end
        return res;
    endfunction

    task automatic load_config(input logic bypass, input sync_sel_t depth);
        @(posedge clk_i);
        #1;
        cfg_i.wwl_high     = cnt_t'(WWL_HIGH);
        cfg_i.wwl_low      = cnt_t'(WWL_LOW);
        cfg_i.spin_write   = cnt_t'(SPIN_WRITE);
        cfg_i.spin_compute = cnt_t'(SPIN_COMPUTE);
        cfg_i.sync_depth   = depth;
        cfg_i.bypass_conv  = bypass;
        spin_wwl_strobe_i  = STROBE_MASK;
        spin_feedback_i    = FEEDBACK_MASK;
        cfg_load_i         = 1'b1;
        @(posedge clk_i);
        #1;
        cfg_load_i = 1'b0;
    endtask

    task automatic check_reset_state();
        @(negedge clk_i);
        check_value("j_one_hot_wwl_o", j_one_hot_wwl_o, 0);
        check_value("h_wwl_o", h_wwl_o, 0);
        check_value("spin_wwl_o", spin_wwl_o, 0);
        check_value("j_mem_ren_o", j_mem_ren_o, 0);
        check_value("h_ren_o", h_ren_o, 0);
        check_value("spin_valid_o", spin_valid_o, 0);
        check_value("spin_pop_ready_o", spin_pop_ready_o, 1);
        check_value("dt_cfg_idle_o", dt_cfg_idle_o, 1);
        check_value("analog_rx_idle_o", analog_rx_idle_o, 1);
        check_value("analog_tx_idle_o", analog_tx_idle_o, 1);
    endtask

    task automatic run_weight_write(input logic bypass);
        logic [WBL_W-1:0] exp_wbl;
        logic [WBL_W-1:0] exp_wblb;
        int               high_cnt;
        int               low_cnt;
        load_config(bypass, sync_sel_t'(1));
        @(posedge clk_i);
        #1;
        dt_cfg_enable_i = 1'b1;
        @(posedge clk_i);
        #1;
        dt_cfg_enable_i = 1'b0;
        @(negedge clk_i);
        for (int r = 0; r <= NUM_SPIN; r++) begin
            // read cycle of row r
            check_value("dt_cfg_idle_o", dt_cfg_idle_o, 0);
            check_value("j_mem_ren_o", j_mem_ren_o, r < NUM_SPIN);
            check_value("h_ren_o", h_ren_o, r == NUM_SPIN);
            if (r < NUM_SPIN) begin
                check_value("j_raddr_o", j_raddr_o, r);
            end
            exp_wbl  = sign_mag_row(weight_mem[r], bypass);
            exp_wblb = ~exp_wbl;
            high_cnt = 0;
            @(negedge clk_i);
            while (j_one_hot_wwl_o != '0 || h_wwl_o) begin
                guard_wait(high_cnt, "end of word line high phase");
                check_value("j_one_hot_wwl_o", j_one_hot_wwl_o,
                            (r < NUM_SPIN) ? (64'd1 << r) : 64'd0);
                check_value("h_wwl_o", h_wwl_o, r == NUM_SPIN);
                check_value("wbl_o", wbl_o, exp_wbl);
                check_value("wblb_o", wblb_o, exp_wblb);
                high_cnt++;
                @(negedge clk_i);
            end
            check_value("word line high cycles", high_cnt, WWL_HIGH);
            low_cnt = 0;
            while (!j_mem_ren_o && !h_ren_o && !dt_cfg_idle_o) begin
                guard_wait(low_cnt, "next row read");
                check_value("wbl_o", wbl_o, exp_wbl);
                check_value("wblb_o", wblb_o, exp_wblb);
                low_cnt++;
                @(negedge clk_i);
            end
            check_value("word line low cycles", low_cnt, WWL_LOW);
        end
        check_value("dt_cfg_idle_o", dt_cfg_idle_o, 1);
    endtask

    task automatic run_spin(input logic [NUM_SPIN-1:0] spin, input logic [NUM_SPIN-1:0] analog,
                            input sync_sel_t depth, input int hold);
        logic [NUM_SPIN-1:0] held;
        int                  waited;
        int                  k;
        load_config(1'b0, depth);
        @(posedge clk_i);
        #1;
        spin_analog_i    = analog;
        spin_pop_i       = spin;
        spin_pop_valid_i = 1'b1;
        waited           = 0;
        @(negedge clk_i);
        while (!spin_pop_ready_o) begin
            guard_wait(waited, "spin_pop_ready_o");
            waited++;
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        spin_pop_valid_i = 1'b0;
        spin_pop_i       = '0;
        k = 1;
        @(negedge clk_i);
        while (!spin_valid_o) begin
            guard_wait(k, "spin_valid_o");
            if (k <= SPIN_WRITE) begin
                check_value("spin_wwl_o", spin_wwl_o, STROBE_MASK);
                check_value("wbl_o", wbl_o, spin_field_row(spin));
                check_value("wblb_o", wblb_o, 0);
                check_value("spin_feedback_o", spin_feedback_o, FEEDBACK_MASK);
                check_value("analog_rx_idle_o", analog_rx_idle_o, 0);
            end else if (k <= SPIN_WRITE + SPIN_COMPUTE) begin
                check_value("spin_wwl_o", spin_wwl_o, 0);
                check_value("spin_feedback_o", spin_feedback_o, FEEDBACK_MASK);
                check_value("analog_rx_idle_o", analog_rx_idle_o, 0);
            end else begin
                check_value("spin_feedback_o", spin_feedback_o, 0);
                check_value("analog_rx_idle_o", analog_rx_idle_o, 1);
                check_value("analog_tx_idle_o", analog_tx_idle_o, 0);
            end
            k++;
            @(negedge clk_i);
        end
        check_value("spin_valid_o latency", k, 1 + SPIN_WRITE + SPIN_COMPUTE + int'(depth));
        check_value("spin_o", spin_o, analog);
        check_value("spin_pop_ready_o", spin_pop_ready_o, 0);
        held = spin_o;
        repeat (hold) begin
            @(negedge clk_i);
            check_value("spin_valid_o", spin_valid_o, 1);
            check_value("spin_o", spin_o, held);
            check_value("spin_pop_ready_o", spin_pop_ready_o, 0);
        end
        @(posedge clk_i);
        #1;
        spin_ready_i = 1'b1;
        @(negedge clk_i);
        check_value("spin_valid_o", spin_valid_o, 1);
        @(posedge clk_i);
        #1;
        spin_ready_i = 1'b0;
        @(negedge clk_i);
        check_value("spin_valid_o", spin_valid_o, 0);
        check_value("spin_pop_ready_o", spin_pop_ready_o, 1);
        check_value("analog_tx_idle_o", analog_tx_idle_o, 1);
    endtask

    initial begin
        clk_i             = 1'b0;
        reset_i           = 1'b1;
        cfg_load_i        = 1'b0;
        cfg_i             = '0;
        spin_wwl_strobe_i = '0;
        spin_feedback_i   = '0;
        dt_cfg_enable_i   = 1'b0;
        j_rdata_i         = '0;
        h_rdata_i         = '0;
        spin_pop_valid_i  = 1'b0;
        spin_pop_i        = '0;
        spin_analog_i     = '0;
        spin_ready_i      = 1'b0;
        lfsr_q            = 16'd19139;
        fill_weights();
        repeat (10) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        check_reset_state();
        run_weight_write(1'b0);
        run_weight_write(1'b1);
        run_spin(8'hA6, 8'h5B, sync_sel_t'(1), 0);
        run_spin(8'h39, 8'hC4, sync_sel_t'(3), 0);
        // stalled consumer, then a second pop behind it
        run_spin(8'h72, 8'h1E, sync_sel_t'(2), 5);
        run_spin(8'h8D, 8'hE1, sync_sel_t'(2), 0);

        repeat (2) @(posedge clk_i);
        if (u_analog_wrap.u_asserts.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stop_with_failure("a bound assertion failed during the run");
        end
    end

endmodule
